// File: filelist.f
+incdir+tb
src/pe_cntl_pkg.sv
src/command_sequencer.sv
src/stop_config_table.sv
src/lane_config_expander.sv
src/pe_cntl_top.sv
tb/pe_cntl_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = pe_cntl_tb
FILELIST  = filelist.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/pe_cntl_tb_ref.svh
// Reference model and bus drivers for the PE control testbench
// Included inside the testbench module and uses its signals and counters
`ifndef PE_CNTL_TB_REF_SVH
`define PE_CNTL_TB_REF_SVH

// 16-bit Fibonacci LFSR with taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
  return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

task automatic draw_word(output logic [31:0] w);
  w = '0;
  for (int b = 0; b < 32; b++)
  begin
    lfsr_state = lfsr_next(lfsr_state);
    w = {w[30:0], lfsr_state[0]};           // One step per bit
  end
endtask

function automatic logic [CHIP_ADDR_W-1:0] with_lane(input logic [CHIP_ADDR_W-1:0] addr,
                                                     input int lane);
  logic [CHIP_ADDR_W-1:0] mask;
  mask = CHIP_ADDR_W'((1 << LANE_BITS) - 1) << LANE_LSB;
  return (addr & ~mask) | (CHIP_ADDR_W'(lane) << LANE_LSB);
endfunction

// Expected lane descriptor for one lane of a table entry
function automatic lane_desc_t expected_lane(input stop_desc_t d, input int lane);
  lane_desc_t l;
  l.src_addr0 = with_lane(d.src_addr0, lane);
  l.dst_addr0 = with_lane(d.dst_addr0, lane);
  l.src_type0 = d.src_type0;
  l.src_addr1 = with_lane(d.src_addr1, lane);
  l.dst_addr1 = with_lane(d.dst_addr1, lane);
  l.src_type1 = d.src_type1;
  l.num_ops   = d.num_ops;
  return l;
endfunction

// One APB transfer; read data and error are taken in the access phase
task automatic apb_access(input logic write, input logic [PTR_W-1:0] entry,
                          input logic [2:0] wsel, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
  @(posedge clk);
  #1;
  apb_req = '{psel: 1'b1, penable: 1'b0, pwrite: write,
              paddr: {entry, wsel, 2'b00}, pwdata: wdata};
  @(posedge clk);
  #1;
  apb_req.penable = 1'b1;
  rdata = apb_rsp.prdata;
  err   = apb_rsp.pslverr;
  if (apb_rsp.pready !== 1'b1)
  begin
    $display("FAIL pready got %h expected 1", apb_rsp.pready);
    apb_errors++;
  end
  @(posedge clk);
  #1;
  apb_req = '0;
endtask

// Holds a beat until accepted, then posts the expected command
task automatic send_beat(input oob_beat_t beat, input logic is_stop,
                         input logic [PTR_W-1:0] ptr);
  @(posedge clk);
  #1;
  oob_beat  = beat;
  oob_valid = 1'b1;
  while (!oob_ready)
  begin
    @(posedge clk);
    #1;
  end
  @(posedge clk);                           // Accepting edge
  #1;
  oob_valid = 1'b0;
  if (is_stop)
  begin
    exp_cycle_q.push_back(cycle);
    exp_ptr_q.push_back(ptr);
  end
endtask

`endif

// File: tb/pe_cntl_tb.sv
// Testbench for pe_cntl_top with APB table fill, OOB commands and completion handshake
// Runs 21 commands and 166 APB accesses; the watchdog is sized from those counts
`default_nettype none

module pe_cntl_tb;
  import pe_cntl_pkg::*;

  localparam int NUM_CMDS   = 21;
  localparam int NUM_APB    = 166;
  localparam int WATCHDOG_CYCLES = 200 * NUM_CMDS + 20 * NUM_APB + 10;

  logic                            clk = 1'b0;
  logic                            reset = 1'b1;
  oob_beat_t                       oob_beat;
  logic                            oob_valid;
  logic                            oob_ready;
  apb_req_t                        apb_req;
  apb_rsp_t                        apb_rsp;
  logic                            stop_complete;
  logic                            stop_enable;
  logic [OP_W-1:0]                 stop_operation;
  lane_desc_t [NUM_LANES-1:0]      lane_desc;

  logic [15:0]      lfsr_state = 16'd28;
  logic [31:0]      mirror_word [TABLE_DEPTH][5];   // Words as the table should hold them
  int               exp_cycle_q [$];                // Accepting edge of each command
  logic [PTR_W-1:0] exp_ptr_q [$];
  int               cycle = 0;
  logic             enable_prev = 1'b0;
  int               apb_errors = 0;
  int               cmd_errors = 0;
  int               hs_errors = 0;

  `include "pe_cntl_tb_ref.svh"

  pe_cntl_top pe_cntl_top_inst (
    .clk            (clk),
    .reset          (reset),
    .oob_beat       (oob_beat),
    .oob_valid      (oob_valid),
    .oob_ready      (oob_ready),
    .apb_req        (apb_req),
    .apb_rsp        (apb_rsp),
    .stop_complete  (stop_complete),
    .stop_enable    (stop_enable),
    .stop_operation (stop_operation),
    .lane_desc      (lane_desc)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
    cycle <= cycle + 1;

  // Unused high bits of a word read back as zero
  function automatic logic [31:0] word_mask(input int w);
    if (w == 0)
      return 32'hFFFF_FFFF;
    if (w == 1 || w == 3)
      return 32'h0FFF_FFFF;
    return 32'h00FF_FFFF;
  endfunction

  function automatic stop_desc_t entry_desc(input int e);
    stop_desc_t d;
    d.operation = mirror_word[e][0][31:16];
    d.num_ops   = mirror_word[e][0][15:0];
    d.src_addr0 = mirror_word[e][1][23:0];
    d.src_type0 = mirror_word[e][1][27:24];
    d.dst_addr0 = mirror_word[e][2][23:0];
    d.src_addr1 = mirror_word[e][3][23:0];
    d.src_type1 = mirror_word[e][3][27:24];
    d.dst_addr1 = mirror_word[e][4][23:0];
    return d;
  endfunction

  // Streaming op model runs a while, raises complete, holds it and drops it
  task automatic finish_command();
    while (!stop_enable)
    begin
      @(posedge clk);
      #1;
    end
    repeat (3) @(posedge clk);
    #1;
    if (stop_enable !== 1'b1 || oob_ready !== 1'b0)
    begin
      $display("FAIL stop_enable/oob_ready got %h/%h expected 1/0", stop_enable, oob_ready);
      hs_errors++;
    end
    stop_complete = 1'b1;
    @(posedge clk);
    #1;
    if (stop_enable !== 1'b0 || oob_ready !== 1'b0)
    begin
      $display("FAIL stop_enable/oob_ready got %h/%h expected 0/0", stop_enable, oob_ready);
      hs_errors++;
    end
    @(posedge clk);                         // Still draining
    #1;
    if (oob_ready !== 1'b0)
    begin
      $display("FAIL oob_ready got %h expected 0", oob_ready);
      hs_errors++;
    end
    stop_complete = 1'b0;
    @(posedge clk);
    #1;
    if (oob_ready !== 1'b1)
    begin
      $display("FAIL oob_ready got %h expected 1", oob_ready);
      hs_errors++;
    end
  endtask

  // ----------------------------------------
  // Compare process on every enable rise
  // ----------------------------------------
  always @(negedge clk)
  begin : compare_outputs
    int               acc;
    logic [PTR_W-1:0] p;
    stop_desc_t       d;
    lane_desc_t       exp_lane;
    if (!reset && stop_enable && !enable_prev)
    begin
      if (exp_ptr_q.size() == 0)
      begin
        $display("stop_enable rose at cycle %0d with no command pending", cycle);
        cmd_errors++;
      end
      else
      begin
        acc = exp_cycle_q.pop_front();
        p   = exp_ptr_q.pop_front();
        d   = entry_desc(int'(p));
        if (cycle - acc != 2)
        begin
          $display("FAIL stop_enable delay got %h expected %h", cycle - acc, 2);
          cmd_errors++;
        end
        if (stop_operation !== d.operation)
        begin
          $display("FAIL stop_operation got %h expected %h", stop_operation, d.operation);
          cmd_errors++;
        end
        for (int i = 0; i < NUM_LANES; i++)
        begin
          exp_lane = expected_lane(d, i);
          if (lane_desc[i] !== exp_lane)
          begin
            $display("FAIL lane_desc[%0d] got %h expected %h", i, lane_desc[i], exp_lane);
            cmd_errors++;
          end
        end
      end
    end
    enable_prev = stop_enable;
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial
  begin : stimulus
    logic [31:0] wd;
    logic [31:0] rd;
    logic        err;
    oob_beat      = '0;
    oob_valid     = 1'b0;
    apb_req       = '0;
    stop_complete = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;

    for (int e = 0; e < TABLE_DEPTH; e++)
      for (int w = 0; w < 5; w++)
      begin
        draw_word(wd);
        apb_access(1'b1, PTR_W'(e), 3'(w), wd, rd, err);
        mirror_word[e][w] = wd & word_mask(w);
      end
    for (int e = 0; e < TABLE_DEPTH; e++)
      for (int w = 0; w < 5; w++)
      begin
        apb_access(1'b0, PTR_W'(e), 3'(w), 32'h0, rd, err);
        if (rd !== mirror_word[e][w] || err !== 1'b0)
        begin
          $display("FAIL prdata/pslverr got %h/%h expected %h/0", rd, err, mirror_word[e][w]);
          apb_errors++;
        end
      end
    for (int w = 5; w < 8; w++)             // Unmapped word slots
    begin
      draw_word(wd);
      apb_access(1'b1, 4'd6, 3'(w), wd, rd, err);
      if (err !== 1'b1)
      begin
        $display("FAIL pslverr got %h expected 1", err);
        apb_errors++;
      end
      apb_access(1'b0, 4'd6, 3'(w), 32'h0, rd, err);
      if (rd !== 32'h0 || err !== 1'b1)
      begin
        $display("FAIL prdata/pslverr got %h/%h expected 0/1", rd, err);
        apb_errors++;
      end
    end

    for (int e = 0; e < TABLE_DEPTH; e++)
    begin
      send_beat({4'd0, 8'h00, OPT_STOP, 8'(e)}, 1'b1, PTR_W'(e));
      finish_command();
    end
    send_beat({OPT_STOP, 8'd9, 4'd2, 8'd5}, 1'b1, 4'd9);        // Slot 1 only
    finish_command();
    send_beat({OPT_STOP, 8'd12, OPT_STOP, 8'd3}, 1'b1, 4'd3);   // Slot 0 wins
    finish_command();

    send_beat({4'd3, 8'd11, 4'd2, 8'd7}, 1'b0, 4'd0);
    if (oob_ready !== 1'b1)
    begin
      $display("FAIL oob_ready got %h expected 1", oob_ready);
      hs_errors++;
    end
    repeat (4) @(posedge clk);
    #1;
    if (stop_enable !== 1'b0)
    begin
      $display("FAIL stop_enable got %h expected 0", stop_enable);
      hs_errors++;
    end

    // Second beat waits under back-pressure
    send_beat({4'd0, 8'h00, OPT_STOP, 8'd14}, 1'b1, 4'd14);
    fork
      send_beat({OPT_STOP, 8'd1, 4'd0, 8'h00}, 1'b1, 4'd1);
      finish_command();
    join
    finish_command();

    repeat (5) @(posedge clk);
    if (exp_ptr_q.size() != 0)
    begin
      $display("%0d accepted commands never raised stop_enable", exp_ptr_q.size());
      hs_errors++;
    end
    $display("Errors: apb %0d, command %0d, handshake %0d", apb_errors, cmd_errors, hs_errors);
    if (apb_errors + cmd_errors + hs_errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  initial
  begin : watchdog
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Watchdog timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/pe_cntl_top.sv
// PE control top level: OOB command in, streaming-op enable and lane descriptors out
// Expects stop_complete to rise and then fall for every command it starts
`default_nettype none

module pe_cntl_top (
  input  logic                                           clk,
  input  logic                                           reset,
  input  pe_cntl_pkg::oob_beat_t                         oob_beat,
  input  logic                                           oob_valid,
  output logic                                           oob_ready,
  input  pe_cntl_pkg::apb_req_t                          apb_req,
  output pe_cntl_pkg::apb_rsp_t                          apb_rsp,
  input  logic                                           stop_complete,
  output logic                                           stop_enable,
  output logic [pe_cntl_pkg::OP_W-1:0]                   stop_operation,
  output pe_cntl_pkg::lane_desc_t [pe_cntl_pkg::NUM_LANES-1:0] lane_desc
);
  import pe_cntl_pkg::*;

  logic [PTR_W-1:0] lookup_ptr;
  logic             lookup_req;
  logic             load;
  stop_desc_t       desc;         // Registered table entry

  // ----------------------------------------
  // Command FSM
  // ----------------------------------------
  command_sequencer command_sequencer_inst (
    .clk           (clk),
    .reset         (reset),
    .oob_beat      (oob_beat),
    .oob_valid     (oob_valid),
    .oob_ready     (oob_ready),
    .stop_complete (stop_complete),
    .stop_enable   (stop_enable),
    .lookup_ptr    (lookup_ptr),
    .lookup_req    (lookup_req),
    .load          (load)
  );

  // Descriptor table, filled over APB
  stop_config_table stop_config_table_inst (
    .clk        (clk),
    .reset      (reset),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .lookup_ptr (lookup_ptr),
    .lookup_req (lookup_req),
    .desc       (desc)
  );

  lane_config_expander lane_config_expander_inst (
    .clk            (clk),
    .reset          (reset),
    .load           (load),
    .desc           (desc),
    .stop_operation (stop_operation),
    .lane_desc      (lane_desc)
  );

endmodule

`default_nettype wire

// File: src/lane_config_expander.sv
// Builds one descriptor per execution lane from the looked-up table entry
// Lane field of every address is forced to the lane index
`default_nettype none

module lane_config_expander (
  input  logic                                           clk,
  input  logic                                           reset,
  input  logic                                           load,
  input  pe_cntl_pkg::stop_desc_t                        desc,
  output logic [pe_cntl_pkg::OP_W-1:0]                   stop_operation,
  output pe_cntl_pkg::lane_desc_t [pe_cntl_pkg::NUM_LANES-1:0] lane_desc
);
  import pe_cntl_pkg::*;

  stop_desc_t desc_q;     // Descriptor of the command in flight

  // ----------------------------------------
  // Lane field substitution
  // ----------------------------------------
  function automatic logic [CHIP_ADDR_W-1:0] set_lane(
    input logic [CHIP_ADDR_W-1:0] addr,
    input logic [LANE_BITS-1:0]   lane
  );
    logic [CHIP_ADDR_W-1:0] res;
    res = addr;
    res[LANE_LSB +: LANE_BITS] = lane;
    return res;
  endfunction

  // Capture on load only
  always_ff @(posedge clk)
  begin
    if (reset)
      desc_q <= '0;
    else if (load)
      desc_q <= desc;
  end

  assign stop_operation = desc_q.operation;

  // ----------------------------------------
  // Per-lane outputs
  // ----------------------------------------
  for (genvar i = 0; i < NUM_LANES; i++)
  begin : g_lane
    localparam logic [LANE_BITS-1:0] LANE_IDX = LANE_BITS'(i);

    assign lane_desc[i] = '{
      src_addr0: set_lane(desc_q.src_addr0, LANE_IDX),
      dst_addr0: set_lane(desc_q.dst_addr0, LANE_IDX),
      src_type0: desc_q.src_type0,                       // Type passes through
      src_addr1: set_lane(desc_q.src_addr1, LANE_IDX),
      dst_addr1: set_lane(desc_q.dst_addr1, LANE_IDX),
      src_type1: desc_q.src_type1,
      num_ops:   desc_q.num_ops                          // Same count on every lane
    };
  end

  // Lane outputs stay put while a streaming op runs
  a_hold_between_loads: assert property (@(posedge clk) disable iff (reset)
    !$past(load) |-> ($stable(stop_operation) && $stable(lane_desc)));

endmodule

`default_nettype wire

// File: src/stop_config_table.sv
// Streaming-op descriptor table with an APB slave port, no wait states
// Word selects 5..7 of an entry answer with pslverr; writes there are dropped
`default_nettype none

module stop_config_table (
  input  logic                          clk,
  input  logic                          reset,
  input  pe_cntl_pkg::apb_req_t         apb_req,
  output pe_cntl_pkg::apb_rsp_t         apb_rsp,
  input  logic [pe_cntl_pkg::PTR_W-1:0] lookup_ptr,
  input  logic                          lookup_req,
  output pe_cntl_pkg::stop_desc_t       desc
);
  import pe_cntl_pkg::*;

  stop_desc_t            table_mem [TABLE_DEPTH];
  stop_desc_t            cur_entry;
  stop_desc_t            desc_q;
  logic [WSEL_W-1:0]     wsel;
  logic [PTR_W-1:0]      entry;
  logic                  setup_phase;
  logic                  access_phase;
  logic                  bad_word;
  logic [APB_DATA_W-1:0] rd_word;
  logic [APB_DATA_W-1:0] prdata_q;
  logic                  pslverr_q;

  // ----------------------------------------
  // APB decode
  // ----------------------------------------
  assign wsel         = apb_req.paddr[WSEL_LSB +: WSEL_W];
  assign entry        = apb_req.paddr[ENTRY_LSB +: PTR_W];
  assign setup_phase  = apb_req.psel && !apb_req.penable;
  assign access_phase = apb_req.psel && apb_req.penable;
  assign bad_word     = (wsel >= WORDS_PER_ENTRY);
  assign cur_entry    = table_mem[entry];

  // Read word packing follows the word map
  always_comb
  begin
    case (wsel)
      WORD_OP:   rd_word = {cur_entry.operation, cur_entry.num_ops};
      WORD_SRC0: rd_word = APB_DATA_W'({cur_entry.src_type0, cur_entry.src_addr0});
      WORD_DST0: rd_word = APB_DATA_W'(cur_entry.dst_addr0);
      WORD_SRC1: rd_word = APB_DATA_W'({cur_entry.src_type1, cur_entry.src_addr1});
      WORD_DST1: rd_word = APB_DATA_W'(cur_entry.dst_addr1);
      default:   rd_word = '0;     // Unmapped slot reads as zero
    endcase
  end

  // ----------------------------------------
  // Table storage and lookup port
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (access_phase && apb_req.pwrite && !bad_word)
    begin
      case (wsel)
        WORD_OP:
        begin
          table_mem[entry].operation <= apb_req.pwdata[NUM_OPS_W +: OP_W];
          table_mem[entry].num_ops   <= apb_req.pwdata[NUM_OPS_W-1:0];
        end
        WORD_SRC0:
        begin
          table_mem[entry].src_addr0 <= apb_req.pwdata[CHIP_ADDR_W-1:0];
          table_mem[entry].src_type0 <= apb_req.pwdata[CHIP_ADDR_W +: DTYPE_W];
        end
        WORD_DST0: table_mem[entry].dst_addr0 <= apb_req.pwdata[CHIP_ADDR_W-1:0];
        WORD_SRC1:
        begin
          table_mem[entry].src_addr1 <= apb_req.pwdata[CHIP_ADDR_W-1:0];
          table_mem[entry].src_type1 <= apb_req.pwdata[CHIP_ADDR_W +: DTYPE_W];
        end
        WORD_DST1: table_mem[entry].dst_addr1 <= apb_req.pwdata[CHIP_ADDR_W-1:0];
        default: ;
      endcase
    end
    if (setup_phase)
      prdata_q <= rd_word;            // Ready for the access phase
    if (lookup_req)
      desc_q <= table_mem[lookup_ptr];
  end

  // Error flag is set up one cycle ahead so it lines up with the access phase
  always_ff @(posedge clk)
  begin
    if (reset)
      pslverr_q <= 1'b0;
    else
      pslverr_q <= setup_phase && bad_word;
  end

  assign apb_rsp = '{prdata: prdata_q, pready: 1'b1, pslverr: pslverr_q};
  assign desc    = desc_q;

  a_pslverr_in_access: assert property (@(posedge clk) disable iff (reset)
    apb_rsp.pslverr |-> (apb_req.psel && apb_req.penable));

endmodule

`default_nettype wire

// File: src/command_sequencer.sv
// OOB command FSM; slot 0 wins when both tuples carry the streaming-op option
// Beats without that option are consumed and dropped
`default_nettype none

module command_sequencer (
  input  logic                          clk,
  input  logic                          reset,
  input  pe_cntl_pkg::oob_beat_t        oob_beat,
  input  logic                          oob_valid,
  output logic                          oob_ready,
  input  logic                          stop_complete,
  output logic                          stop_enable,
  output logic [pe_cntl_pkg::PTR_W-1:0] lookup_ptr,
  output logic                          lookup_req,
  output logic                          load
);
  import pe_cntl_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    LOAD,
    RUN,
    DRAIN
  } state_t;

  state_t           state;
  logic             accept;
  logic             has_stop;
  logic [PTR_W-1:0] sel_ptr;
  logic [PTR_W-1:0] ptr_q;

  // ----------------------------------------
  // Tuple decode
  // ----------------------------------------
  always_comb
  begin
    has_stop = 1'b0;
    sel_ptr  = '0;
    if (oob_beat.slot0.opt == OPT_STOP)
    begin
      has_stop = 1'b1;
      sel_ptr  = oob_beat.slot0.value[PTR_W-1:0];
    end
    else if (oob_beat.slot1.opt == OPT_STOP)
    begin
      has_stop = 1'b1;
      sel_ptr  = oob_beat.slot1.value[PTR_W-1:0];
    end
  end

  assign accept = oob_valid && oob_ready;

  // Pointer is held for the lookup cycle
  always_ff @(posedge clk)
  begin
    if (accept && has_stop)
      ptr_q <= sel_ptr;
  end

  assign lookup_ptr = ptr_q;
  assign lookup_req = (state == LOOKUP);
  assign load       = (state == LOAD);    // Table output valid this cycle

  // ----------------------------------------
  // Sequencing and completion handshake
  // ----------------------------------------
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state       <= IDLE;
      oob_ready   <= 1'b1;
      stop_enable <= 1'b0;
    end
    else
    begin
      case (state)
        IDLE:
          if (accept && has_stop)
          begin
            state     <= LOOKUP;
            oob_ready <= 1'b0;              // Hold off further beats
          end
        LOOKUP:
          state <= LOAD;
        LOAD:
        begin
          state       <= RUN;
          stop_enable <= 1'b1;              // Rises with the new lane descriptors
        end
        RUN:
          if (stop_complete)
          begin
            state       <= DRAIN;
            stop_enable <= 1'b0;
          end
        DRAIN:
          // Streaming op must drop complete before the next command
          if (!stop_complete)
          begin
            state     <= IDLE;
            oob_ready <= 1'b1;
          end
        default:
          state <= IDLE;
      endcase
    end
  end

  a_no_enable_in_idle: assert property (@(posedge clk) disable iff (reset)
    (state == IDLE) |-> !stop_enable);

  a_ready_only_in_idle: assert property (@(posedge clk) disable iff (reset)
    (state != IDLE) |-> !oob_ready);

endmodule

`default_nettype wire

// File: src/pe_cntl_pkg.sv
// Widths, option codes, APB word map and bus types for the PE control block
// Only one streaming op may be in flight; the table is loaded over APB only
`default_nettype none

package pe_cntl_pkg;

  // ----------------------------------------
  // Addressing and operation widths
  // ----------------------------------------
  localparam int CHIP_ADDR_W = 24;
  localparam int NUM_LANES   = 4;
  localparam int LANE_BITS   = 2;
  localparam int LANE_LSB    = 10;          // Lane field sits at [11:10]
  localparam int DTYPE_W     = 4;           // bit, nibble, byte, word
  localparam int NUM_OPS_W   = 16;
  localparam int OP_W        = 16;

  // Descriptor table
  localparam int TABLE_DEPTH = 16;
  localparam int PTR_W       = 4;

  // OOB option codes
  localparam int OPT_W = 4;
  localparam logic [OPT_W-1:0] OPT_STOP = 4'd1;   // Value is a table pointer

  // ----------------------------------------
  // APB word map
  // ----------------------------------------
  localparam int APB_ADDR_W = 9;
  localparam int APB_DATA_W = 32;
  localparam int WSEL_LSB   = 2;            // Byte bits 1..0 ignored
  localparam int WSEL_W     = 3;
  localparam int ENTRY_LSB  = 5;            // Eight word slots per entry

  localparam logic [WSEL_W-1:0] WORDS_PER_ENTRY = 3'd5;
  localparam logic [WSEL_W-1:0] WORD_OP   = 3'd0;  // {operation, num_ops}
  localparam logic [WSEL_W-1:0] WORD_SRC0 = 3'd1;  // {type0, src addr0}
  localparam logic [WSEL_W-1:0] WORD_DST0 = 3'd2;
  localparam logic [WSEL_W-1:0] WORD_SRC1 = 3'd3;  // {type1, src addr1}
  localparam logic [WSEL_W-1:0] WORD_DST1 = 3'd4;

  // ----------------------------------------
  // Bus and descriptor types
  // ----------------------------------------
  typedef struct packed {
    logic [OPT_W-1:0] opt;
    logic [7:0]       value;
  } oob_tuple_t;

  // Slot 0 occupies the low bits
  typedef struct packed {
    oob_tuple_t slot1;
    oob_tuple_t slot0;
  } oob_beat_t;

  typedef struct packed {
    logic [OP_W-1:0]        operation;
    logic [CHIP_ADDR_W-1:0] src_addr0;
    logic [CHIP_ADDR_W-1:0] dst_addr0;
    logic [DTYPE_W-1:0]     src_type0;
    logic [CHIP_ADDR_W-1:0] src_addr1;
    logic [CHIP_ADDR_W-1:0] dst_addr1;
    logic [DTYPE_W-1:0]     src_type1;
    logic [NUM_OPS_W-1:0]   num_ops;
  } stop_desc_t;

  // Per-lane view, lane field already substituted
  typedef struct packed {
    logic [CHIP_ADDR_W-1:0] src_addr0;
    logic [CHIP_ADDR_W-1:0] dst_addr0;
    logic [DTYPE_W-1:0]     src_type0;
    logic [CHIP_ADDR_W-1:0] src_addr1;
    logic [CHIP_ADDR_W-1:0] dst_addr1;
    logic [DTYPE_W-1:0]     src_type1;
    logic [NUM_OPS_W-1:0]   num_ops;
  } lane_desc_t;

  typedef struct packed {
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [APB_ADDR_W-1:0] paddr;
    logic [APB_DATA_W-1:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [APB_DATA_W-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire
